// File: mips_core.f
mips_pkg.sv
control.sv
execute.sv
regfile.sv
data_mem.sv
pc_unit.sv
mips_core.sv
tb_mips_core.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mips_core -f mips_core.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_mips_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

grep -qx "All tests passed" sim.log || exit 1
exit 0

// File: tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;

	logic             clk = 1'b0;
	logic             rst_n;
	mips_pkg::instr_t instr = '0;
	logic [31:0]      pc;
	logic             rf_we;
	logic [4:0]       rf_waddr;
	logic [31:0]      rf_wdata;
	logic             dm_we;
	logic [31:0]      dm_addr;
	logic [31:0]      dm_wdata;

	// ******************************
	// program and reference model
	// ******************************
	logic [31:0] prog [256];
	logic [31:0] m_regs [32];
	logic [31:0] m_mem [mips_pkg::DM_WORDS];
	logic [31:0] m_pc = 32'h0;
	// expected effects of the word now on instr
	logic        e_rf_we = 1'b0;
	logic [4:0]  e_waddr = 5'd0;
	logic [31:0] e_wdata = 32'h0;
	logic        e_dm_we = 1'b0;
	logic [31:0] e_addr = 32'h0;
	logic [31:0] e_dwdata = 32'h0;
	logic [31:0] e_npc = 32'h0;
	logic [31:0] test_end [6];
	int          errors = 0;
	int          cycle = 0;
	int          wp = 0;
	string       names [6] = '{"reset", "arithmetic", "immediate", "memory", "branch and jump",
		"nop and unknown"};

	mips_core dut (
		.clk(clk), .rst_n(rst_n), .instr(instr), .pc(pc),
		.rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.dm_we(dm_we), .dm_addr(dm_addr), .dm_wdata(dm_wdata)
	);

	always #2 clk = ~clk;

	task automatic emit(input logic [31:0] w);
		prog[wp] = w;
		wp++;
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	// MIPS rules applied to the model state
	task automatic predict(input mips_pkg::instr_t w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] pc4;
		a = m_regs[w.r.rs];
		b = m_regs[w.r.rt];
		simm = {{16{w.i.imm16[15]}}, w.i.imm16};
		pc4 = m_pc + 32'd4;
		e_rf_we = 1'b0;
		e_dm_we = 1'b0;
		e_waddr = w.i.rt;
		e_wdata = 32'h0;
		e_addr = a + simm;
		e_dwdata = b;
		e_npc = pc4;
		case (w.r.op)
			mips_pkg::OP_RTYPE: begin
				e_rf_we = (w.r.funct == mips_pkg::FUNCT_ADDU) || (w.r.funct == mips_pkg::FUNCT_SUBU);
				e_waddr = w.r.rd;
				e_wdata = (w.r.funct == mips_pkg::FUNCT_ADDU) ? a + b : a - b;
			end
			mips_pkg::OP_ORI: {e_rf_we, e_wdata} = {1'b1, a | {16'h0, w.i.imm16}};
			mips_pkg::OP_LUI: {e_rf_we, e_wdata} = {1'b1, w.i.imm16, 16'h0};
			mips_pkg::OP_LW:  {e_rf_we, e_wdata} = {1'b1, m_mem[e_addr[9:2]]};
			mips_pkg::OP_SW:  e_dm_we = 1'b1;
			mips_pkg::OP_BEQ: e_npc = (a == b) ? pc4 + (simm << 2) : pc4;
			mips_pkg::OP_JAL: begin
				{e_rf_we, e_waddr, e_wdata} = {1'b1, mips_pkg::LINK_REG, pc4};
				e_npc = {pc4[31:28], w.j.index26, 2'b00};
			end
			default: ;
		endcase
	endtask

	// store and ori words while in reset, which must not write
	// fetch from the program on the falling edge after that
	always @(negedge clk) begin
		if (cycle < 4)
			instr = cycle[0] ? {mips_pkg::OP_SW, 5'd0, 5'd0, 16'h0000}
				: {mips_pkg::OP_ORI, 5'd0, 5'd16, 16'h1234};
		else
			instr = prog[pc[9:2]];
		predict(instr);
	end

	always @(posedge clk) begin
		cycle++;
		if (!rst_n) begin
			m_pc = 32'h0;
			m_regs = '{default: 32'h0};
			m_mem = '{default: 32'h0};
		end else begin
			if (e_rf_we && e_waddr != 5'd0)
				m_regs[e_waddr] = e_wdata;
			if (e_dm_we)
				m_mem[e_addr[9:2]] = e_dwdata;
			m_pc = e_npc;
		end
	end

	// ******************************
	// checks
	// ******************************
	assert property (@(posedge clk) (cycle > 0) |-> (pc == m_pc))
		else report_failure($sformatf("pc %h, expected %h", $sampled(pc), $sampled(m_pc)));
	assert property (@(posedge clk) (cycle > 0) |->
		(rf_we == (rst_n && e_rf_we) && dm_we == (rst_n && e_dm_we)))
		else report_failure($sformatf("write strobes wrong at pc %h", $sampled(pc)));
	assert property (@(posedge clk) (rst_n && e_rf_we) |->
		(rf_waddr == e_waddr && rf_wdata == e_wdata))
		else report_failure($sformatf("register write r%0d = %h, expected r%0d = %h",
			$sampled(rf_waddr), $sampled(rf_wdata), $sampled(e_waddr), $sampled(e_wdata)));
	assert property (@(posedge clk) (rst_n && e_dm_we) |->
		(dm_addr == e_addr && dm_wdata == e_dwdata))
		else report_failure($sformatf("memory write %h at %h, expected %h at %h",
			$sampled(dm_wdata), $sampled(dm_addr), $sampled(e_dwdata), $sampled(e_addr)));

	initial begin
		logic [31:0] r1v;
		logic [31:0] r2v;
		logic        reached;
		int          base_err;
		int          n;
		void'($urandom(32'h9ff0));
		rst_n = 1'b0;
		reached = 1'b1;
		base_err = 0;
		r1v = $urandom();
		r2v = $urandom();
		if (r2v == r1v)
			r2v = ~r1v;
		// unused words hold unknown opcodes tagged with their index
		for (int k = 0; k < 256; k++)
			prog[k] = {6'h3f, 26'(k)};
		emit(32'h0);
		test_end[0] = 32'(wp * 4);
		emit({mips_pkg::OP_LUI, 5'd0, 5'd1, r1v[31:16]});
		emit({mips_pkg::OP_ORI, 5'd1, 5'd1, r1v[15:0]});
		emit({mips_pkg::OP_LUI, 5'd0, 5'd2, r2v[31:16]});
		emit({mips_pkg::OP_ORI, 5'd2, 5'd2, r2v[15:0]});
		emit({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, mips_pkg::FUNCT_ADDU});
		emit({6'h00, 5'd1, 5'd2, 5'd4, 5'd0, mips_pkg::FUNCT_SUBU});
		emit({6'h00, 5'd2, 5'd1, 5'd5, 5'd0, mips_pkg::FUNCT_SUBU});
		// write $0, then read it back
		emit({6'h00, 5'd1, 5'd2, 5'd0, 5'd0, mips_pkg::FUNCT_ADDU});
		emit({6'h00, 5'd0, 5'd1, 5'd6, 5'd0, mips_pkg::FUNCT_ADDU});
		test_end[1] = 32'(wp * 4);
		// top bit of $7 clear, ori into $9 with imm bit 15 set
		emit({mips_pkg::OP_LUI, 5'd0, 5'd7, 1'b0, 15'($urandom())});
		emit({mips_pkg::OP_ORI, 5'd1, 5'd8, 16'($urandom())});
		emit({mips_pkg::OP_ORI, 5'd7, 5'd9, 1'b1, 15'($urandom())});
		emit({mips_pkg::OP_LUI, 5'd0, 5'd10, 16'hffff});
		test_end[2] = 32'(wp * 4);
		emit({mips_pkg::OP_ORI, 5'd0, 5'd11, 16'h0200});
		emit({mips_pkg::OP_SW, 5'd11, 5'd1, 16'h0008});
		emit({mips_pkg::OP_SW, 5'd11, 5'd2, 16'hfffc});
		emit({mips_pkg::OP_SW, 5'd11, 5'd3, 16'hfff0});
		emit({mips_pkg::OP_LW, 5'd11, 5'd12, 16'h0008});
		emit({mips_pkg::OP_LW, 5'd11, 5'd13, 16'hfffc});
		emit({mips_pkg::OP_LW, 5'd11, 5'd14, 16'hfff0});
		emit({mips_pkg::OP_LW, 5'd11, 5'd15, 16'h0010});
		test_end[3] = 32'(wp * 4);
		// taken skip, not taken, jal forward, backward branch, exit
		emit({mips_pkg::OP_BEQ, 5'd1, 5'd1, 16'd2});
		emit({mips_pkg::OP_ORI, 5'd0, 5'd20, 16'hdead});
		emit({mips_pkg::OP_ORI, 5'd0, 5'd20, 16'hbeef});
		emit({mips_pkg::OP_BEQ, 5'd1, 5'd2, 16'd4});
		emit({mips_pkg::OP_JAL, 26'(wp + 3)});
		emit({mips_pkg::OP_ORI, 5'd0, 5'd21, 16'h0055});
		emit({mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'd1});
		emit({mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'hfffd});
		test_end[4] = 32'(wp * 4);
		emit(32'h0);
		emit({6'h3f, 26'h2a5f00f});
		emit({6'h00, 5'd1, 5'd2, 5'd22, 5'd0, 6'h20});
		test_end[5] = 32'(wp * 4);
		emit({mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'hffff});
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		for (int t = 0; t < 6 && reached; t++) begin
			n = 0;
			while (pc != test_end[t] && n < 64) begin
				@(negedge clk);
				n++;
			end
			reached = (pc == test_end[t]);
			if (!reached)
				$display("pc never reached address %h within 64 cycles", test_end[t]);
			$display("test %0d %s: %s", t + 1, names[t],
				(reached && errors == base_err) ? "ok" : "FAILED");
			base_err = errors;
		end
		$display("%0d check errors, run %s", errors, reached ? "complete" : "stopped early");
		if (errors == 0 && reached)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: mips_core.sv
`timescale 1ns/1ps

module mips_core (
	input  logic             clk,
	input  logic             rst_n,
	input  mips_pkg::instr_t instr,
	output logic [31:0]      pc,
	output logic             rf_we,
	output logic [4:0]       rf_waddr,
	output logic [31:0]      rf_wdata,
	output logic             dm_we,
	output logic [31:0]      dm_addr,
	output logic [31:0]      dm_wdata
);

	logic [4:0]  rf_raddr1;
	logic [4:0]  rf_raddr2;
	logic [1:0]  wd_sel;
	logic [1:0]  alu_op;
	logic [1:0]  ext_mode;
	logic [1:0]  npc_mode;
	logic        alu_src_imm;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] alu_result;
	logic        equal;
	logic [31:0] dm_rdata;
	logic [31:0] pc_plus4;

	// ******************************
	// decode
	// ******************************
	control u_control (
		.instr(instr), .rst_n(rst_n),
		.rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2), .rf_waddr(rf_waddr),
		.wd_sel(wd_sel), .alu_op(alu_op), .ext_mode(ext_mode), .npc_mode(npc_mode),
		.alu_src_imm(alu_src_imm), .rf_we(rf_we), .dm_we(dm_we)
	);

	// ******************************
	// execute and result
	// ******************************
	execute u_execute (
		.instr(instr), .rs_val(rs_val), .rt_val(rt_val),
		.alu_op(alu_op), .ext_mode(ext_mode), .alu_src_imm(alu_src_imm),
		.alu_result(alu_result), .equal(equal)
	);

	regfile u_regfile (
		.clk(clk), .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
		.rf_waddr(rf_waddr), .rf_we(rf_we), .wd_sel(wd_sel),
		.alu_result(alu_result), .dm_rdata(dm_rdata), .pc_plus4(pc_plus4),
		.rs_val(rs_val), .rt_val(rt_val), .rf_wdata(rf_wdata)
	);

	assign dm_addr  = alu_result;
	assign dm_wdata = rt_val;

	data_mem u_data_mem (
		.clk(clk), .dm_we(dm_we), .dm_addr(dm_addr),
		.dm_wdata(dm_wdata), .dm_rdata(dm_rdata)
	);

	// next address
	pc_unit u_pc_unit (
		.clk(clk), .rst_n(rst_n), .instr(instr),
		.npc_mode(npc_mode), .equal(equal),
		.pc(pc), .pc_plus4(pc_plus4)
	);

endmodule

// File: pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
	input  logic             clk,
	input  logic             rst_n,
	input  mips_pkg::instr_t instr,
	input  logic [1:0]       npc_mode,
	input  logic             equal,
	output logic [31:0]      pc,
	output logic [31:0]      pc_plus4
);

	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic [31:0] next_pc;

	assign pc_plus4 = pc + 32'd4;

	// word offset relative to the delay-free pc + 4
	assign branch_target = pc_plus4 + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
	assign jump_target   = {pc_plus4[31:28], instr.j.index26, 2'b00};

	always_comb begin
		case (npc_mode)
			mips_pkg::NPC_BEQ:  next_pc = equal ? branch_target : pc_plus4;
			mips_pkg::NPC_JUMP: next_pc = jump_target;
			default:            next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= 32'h0;
		end else begin
			pc <= next_pc;
		end
	end

endmodule

// File: data_mem.sv
`timescale 1ns/1ps

module data_mem (
	input  logic        clk,
	input  logic        dm_we,
	input  logic [31:0] dm_addr,
	input  logic [31:0] dm_wdata,
	output logic [31:0] dm_rdata
);

	logic [31:0]                       mem [mips_pkg::DM_WORDS];
	logic [mips_pkg::DM_ADDR_BITS-1:0] word_idx;

	initial begin
		for (int k = 0; k < mips_pkg::DM_WORDS; k++) begin
			mem[k] = 32'h0;
		end
	end

	// word index, byte offset dropped
	assign word_idx = dm_addr[mips_pkg::DM_ADDR_BITS+1:2];

	always_ff @(posedge clk) begin
		if (dm_we) begin
			mem[word_idx] <= dm_wdata;
		end
	end

	assign dm_rdata = mem[word_idx];

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic        clk,
	input  logic [4:0]  rf_raddr1,
	input  logic [4:0]  rf_raddr2,
	input  logic [4:0]  rf_waddr,
	input  logic        rf_we,
	input  logic [1:0]  wd_sel,
	input  logic [31:0] alu_result,
	input  logic [31:0] dm_rdata,
	input  logic [31:0] pc_plus4,
	output logic [31:0] rs_val,
	output logic [31:0] rt_val,
	output logic [31:0] rf_wdata
);

	logic [31:0] regs [32];

	initial begin
		for (int k = 0; k < 32; k++) begin
			regs[k] = 32'h0;
		end
	end

	// write-back source
	always_comb begin
		case (wd_sel)
			mips_pkg::WD_MEM: rf_wdata = dm_rdata;
			mips_pkg::WD_PC4: rf_wdata = pc_plus4;
			default:          rf_wdata = alu_result;
		endcase
	end

	// $0 is never stored
	always_ff @(posedge clk) begin
		if (rf_we && rf_waddr != 5'd0) begin
			regs[rf_waddr] <= rf_wdata;
		end
	end

	assign rs_val = (rf_raddr1 == 5'd0) ? 32'h0 : regs[rf_raddr1];
	assign rt_val = (rf_raddr2 == 5'd0) ? 32'h0 : regs[rf_raddr2];

endmodule

// File: execute.sv
`timescale 1ns/1ps

module execute (
	input  mips_pkg::instr_t instr,
	input  logic [31:0]      rs_val,
	input  logic [31:0]      rt_val,
	input  logic [1:0]       alu_op,
	input  logic [1:0]       ext_mode,
	input  logic             alu_src_imm,
	output logic [31:0]      alu_result,
	output logic             equal
);

	logic [31:0] imm_ext;
	logic [31:0] operand_b;

	// ******************************
	// immediate extension
	// ******************************
	always_comb begin
		case (ext_mode)
			mips_pkg::EXT_SIGN: imm_ext = {{16{instr.i.imm16[15]}}, instr.i.imm16};
			mips_pkg::EXT_PAD:  imm_ext = {instr.i.imm16, 16'h0000};
			default:            imm_ext = {16'h0000, instr.i.imm16};
		endcase
	end

	assign operand_b = alu_src_imm ? imm_ext : rt_val;

	// ******************************
	// alu
	// ******************************
	// wraps on overflow, no trap
	always_comb begin
		case (alu_op)
			mips_pkg::ALU_ADD: alu_result = rs_val + operand_b;
			mips_pkg::ALU_SUB: alu_result = rs_val - operand_b;
			default:           alu_result = rs_val | operand_b;
		endcase
	end

	// branch compare on the raw register values
	assign equal = (rs_val == rt_val);

endmodule

// File: control.sv
`timescale 1ns/1ps

module control (
	input  mips_pkg::instr_t instr,
	input  logic             rst_n,
	output logic [4:0]       rf_raddr1,
	output logic [4:0]       rf_raddr2,
	output logic [4:0]       rf_waddr,
	output logic [1:0]       wd_sel,
	output logic [1:0]       alu_op,
	output logic [1:0]       ext_mode,
	output logic [1:0]       npc_mode,
	output logic             alu_src_imm,
	output logic             rf_we,
	output logic             dm_we
);

	logic [3:0] kind;

	// ******************************
	// classify the word
	// ******************************
	always_comb begin
		case (instr.r.op)
			mips_pkg::OP_RTYPE: begin
				case (instr.r.funct)
					mips_pkg::FUNCT_ADDU: kind = mips_pkg::KIND_ADDU;
					mips_pkg::FUNCT_SUBU: kind = mips_pkg::KIND_SUBU;
					mips_pkg::FUNCT_NOP:  kind = mips_pkg::KIND_NOP;
					default:              kind = mips_pkg::KIND_UNKNOWN;
				endcase
			end
			mips_pkg::OP_ORI: kind = mips_pkg::KIND_ORI;
			mips_pkg::OP_LUI: kind = mips_pkg::KIND_LUI;
			mips_pkg::OP_LW:  kind = mips_pkg::KIND_LW;
			mips_pkg::OP_SW:  kind = mips_pkg::KIND_SW;
			mips_pkg::OP_BEQ: kind = mips_pkg::KIND_BEQ;
			mips_pkg::OP_JAL: kind = mips_pkg::KIND_JAL;
			default:          kind = mips_pkg::KIND_UNKNOWN;
		endcase
	end

	assign rf_raddr1 = instr.r.rs;
	assign rf_raddr2 = instr.r.rt;

	// ******************************
	// selects from the kind
	// ******************************
	always_comb begin
		// defaults act as a no-op
		rf_waddr    = instr.i.rt;
		wd_sel      = mips_pkg::WD_ALU;
		alu_op      = mips_pkg::ALU_OR;
		ext_mode    = mips_pkg::EXT_ZERO;
		npc_mode    = mips_pkg::NPC_SEQ;
		alu_src_imm = 1'b0;
		rf_we       = 1'b0;
		dm_we       = 1'b0;
		case (kind)
			mips_pkg::KIND_ADDU, mips_pkg::KIND_SUBU: begin
				rf_waddr = instr.r.rd;
				alu_op   = (kind == mips_pkg::KIND_ADDU) ? mips_pkg::ALU_ADD : mips_pkg::ALU_SUB;
				rf_we    = 1'b1;
			end
			mips_pkg::KIND_ORI, mips_pkg::KIND_LUI: begin
				ext_mode    = (kind == mips_pkg::KIND_LUI) ? mips_pkg::EXT_PAD : mips_pkg::EXT_ZERO;
				alu_src_imm = 1'b1;
				rf_we       = 1'b1;
			end
			mips_pkg::KIND_LW, mips_pkg::KIND_SW: begin
				wd_sel      = mips_pkg::WD_MEM;
				alu_op      = mips_pkg::ALU_ADD;
				ext_mode    = mips_pkg::EXT_SIGN;
				alu_src_imm = 1'b1;
				rf_we       = (kind == mips_pkg::KIND_LW);
				dm_we       = (kind == mips_pkg::KIND_SW);
			end
			mips_pkg::KIND_BEQ: npc_mode = mips_pkg::NPC_BEQ;
			mips_pkg::KIND_JAL: begin
				rf_waddr = mips_pkg::LINK_REG;
				wd_sel   = mips_pkg::WD_PC4;
				npc_mode = mips_pkg::NPC_JUMP;
				rf_we    = 1'b1;
			end
			default: ;
		endcase
		// no state changes while held in reset
		if (!rst_n) begin
			rf_we = 1'b0;
			dm_we = 1'b0;
		end
	end

endmodule

// File: mips_pkg.sv
package mips_pkg;

	// ******************************
	// opcode and funct values
	// ******************************
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_JAL   = 6'h03;

	localparam logic [5:0] FUNCT_ADDU = 6'h21;
	localparam logic [5:0] FUNCT_SUBU = 6'h23;
	localparam logic [5:0] FUNCT_NOP  = 6'h00;

	// instruction kinds seen by the decoder
	localparam logic [3:0] KIND_ADDU    = 4'd0;
	localparam logic [3:0] KIND_SUBU    = 4'd1;
	localparam logic [3:0] KIND_ORI     = 4'd2;
	localparam logic [3:0] KIND_LUI     = 4'd3;
	localparam logic [3:0] KIND_LW      = 4'd4;
	localparam logic [3:0] KIND_SW      = 4'd5;
	localparam logic [3:0] KIND_BEQ     = 4'd6;
	localparam logic [3:0] KIND_JAL     = 4'd7;
	localparam logic [3:0] KIND_NOP     = 4'd8;
	localparam logic [3:0] KIND_UNKNOWN = 4'd9;

	// ******************************
	// control select codes
	// ******************************
	localparam logic [1:0] ALU_ADD = 2'd0;
	localparam logic [1:0] ALU_SUB = 2'd1;
	localparam logic [1:0] ALU_OR  = 2'd2;

	localparam logic [1:0] EXT_ZERO = 2'd0;
	localparam logic [1:0] EXT_SIGN = 2'd1;
	localparam logic [1:0] EXT_PAD  = 2'd2;

	localparam logic [1:0] WD_ALU = 2'd0;
	localparam logic [1:0] WD_MEM = 2'd1;
	localparam logic [1:0] WD_PC4 = 2'd2;

	localparam logic [1:0] NPC_SEQ  = 2'd0;
	localparam logic [1:0] NPC_BEQ  = 2'd1;
	localparam logic [1:0] NPC_JUMP = 2'd2;

	// jal links into $ra
	localparam logic [4:0] LINK_REG = 5'd31;

	localparam int DM_WORDS     = 256;
	localparam int DM_ADDR_BITS = $clog2(DM_WORDS);

	// ******************************
	// instruction word views
	// ******************************
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} i_fields_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] index26;
	} j_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		j_fields_t j;
	} instr_t;

endpackage
